/* verilog/net_pkg.sv */
/*
  Shared types and constants of the network address controller.
  Referenced by scoped name from every RTL module.
*/
`default_nettype none

package net_pkg;

  // --------------------
  // basic network types
  // --------------------
  typedef logic [31:0] ip_addr_t;
  typedef logic [47:0] mac_addr_t;

  // raw PHY report, speed code 01 = 100M, 10 = 1G
  typedef struct packed {
    logic [1:0] speed;
    logic       duplex;
  } phy_status_t;

  // decoded DHCP offer, lease counted in seconds
  typedef struct packed {
    ip_addr_t    addr;
    logic [31:0] lease;
  } dhcp_offer_t;

  // origin of the committed local address
  typedef enum logic [1:0] {
    src_none       = 2'd0,
    src_static     = 2'd1,
    src_dhcp       = 2'd2,
    src_link_local = 2'd3
  } addr_source_e;

  // acquisition controller states
  typedef enum logic [2:0] {
    st_wait_link    = 3'd0,
    st_settle       = 3'd1,
    st_dhcp_request = 3'd2,
    st_dhcp_wait    = 3'd3,
    st_dhcp_hold    = 3'd4,
    st_running      = 3'd5
  } net_state_e;

  // fsm to result stage, address only meaningful for dhcp
  typedef struct packed {
    addr_source_e source;
    ip_addr_t     dhcp_ip;
  } addr_commit_t;

  // --------------------
  // timing constants
  // --------------------
  localparam logic [31:0] DEFAULT_TICKS_PER_SECOND = 32'd2_500_000;

  // all second counts fit the 5 bit acquisition counter
  localparam logic [4:0] SETTLE_SECONDS       = 5'd1;
  localparam logic [4:0] DHCP_GIVE_UP_SECONDS = 5'd15;
  localparam logic [4:0] DHCP_RETRY_1         = 5'd1;
  localparam logic [4:0] DHCP_RETRY_2         = 5'd3;
  localparam logic [4:0] DHCP_RETRY_3         = 5'd7;

  // twelve hours when the server gives no lease
  localparam logic [31:0] DEFAULT_RENEW_SECONDS = 32'd43_200;

  // retry holdoff is one second shifted down, i.e. 1/16 s
  localparam int unsigned HOLDOFF_SHIFT = 4;

  // 169.254.x.y
  localparam logic [15:0] LINK_LOCAL_PREFIX = {8'd169, 8'd254};

endpackage

`default_nettype wire

/* verilog/net_input_decode.sv */
/*
  Brings the asynchronous PHY status into tx_clock and decodes link state.
  Also flags whether the configured static address is usable.
*/
`timescale 1ns/1ps
`default_nettype none

module net_input_decode (
  input  wire                  tx_clock,
  input  wire                  arst_n,
  input  net_pkg::phy_status_t phy_status,
  input  net_pkg::ip_addr_t    static_ip,
  output logic                 link_up,
  output logic                 speed_1gb,
  output logic                 static_valid
);

  // --------------------
  // synchroniser
  // --------------------
  net_pkg::phy_status_t phy_meta;
  net_pkg::phy_status_t phy_sync;

  // two stage sync, bits are independent levels from the PHY
  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n) begin
      phy_meta <= '0;
      phy_sync <= '0;
    end else begin
      phy_meta <= phy_status;
      phy_sync <= phy_meta;
    end
  end

  // --------------------
  // decode
  // --------------------
  // link counts as up only at full duplex with a legal speed code
  // (00 and 11 are not valid speeds)
  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n) begin
      link_up   <= 1'b0;
      speed_1gb <= 1'b0;
    end else begin
      link_up   <= phy_sync.duplex && (phy_sync.speed[1] != phy_sync.speed[0]);
      // upper bit alone marks gigabit
      speed_1gb <= phy_sync.speed[1];
    end
  end

  // zero and broadcast are both treated as unset
  assign static_valid = (static_ip != '0) && (static_ip != '1);

endmodule

`default_nettype wire

/* verilog/second_timer.sv */
/*
  Restartable seconds prescaler with a one-shot retry holdoff strobe.
  The acquisition FSM restarts it to align seconds to its own events.
*/
`timescale 1ns/1ps
`default_nettype none

module second_timer #(
  parameter logic [31:0] TICKS_PER_SECOND = net_pkg::DEFAULT_TICKS_PER_SECOND
) (
  input  wire  tx_clock,
  input  wire  arst_n,
  input  wire  restart,
  output logic second_tick,
  output logic holdoff_tick
);

  localparam int CNT_W = $clog2(TICKS_PER_SECOND);
  localparam logic [CNT_W-1:0] LOAD = CNT_W'(TICKS_PER_SECOND - 1);
  // count value reached one holdoff period after restart
  localparam logic [CNT_W-1:0] HOLD_MATCH =
    CNT_W'(TICKS_PER_SECOND - (TICKS_PER_SECOND >> net_pkg::HOLDOFF_SHIFT));

  logic [CNT_W-1:0] count;
  logic             armed;

  // countdown, reloads on restart and on wrap
  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n) begin
      count <= LOAD;
      armed <= 1'b0;
    end else if (restart) begin
      count <= LOAD;
      armed <= 1'b1;
    end else begin
      count <= (count == '0) ? LOAD : count - 1'b1;
      // holdoff fires once per restart
      if (holdoff_tick) armed <= 1'b0;
    end
  end

  assign second_tick  = (count == '0);
  assign holdoff_tick = armed && (count == HOLD_MATCH);

endmodule

`default_nettype wire

/* verilog/addr_acquire_fsm.sv */
/*
  Address acquisition FSM: link settle, static use, DHCP with retries,
  link-local fallback after 15 s, and renewal at half the lease.
*/
`timescale 1ns/1ps
`default_nettype none

module addr_acquire_fsm #(
  parameter logic [31:0] TICKS_PER_SECOND = net_pkg::DEFAULT_TICKS_PER_SECOND
) (
  input  wire                   tx_clock,
  input  wire                   arst_n,
  input  wire                   link_up,
  input  wire                   static_valid,
  input  wire                   offer_valid,
  input  net_pkg::dhcp_offer_t  offer,
  output logic                  dhcp_request,
  output logic                  dhcp_listen,
  output logic                  dhcp_timeout,
  output net_pkg::net_state_e   net_state,
  output logic                  commit_valid,
  output net_pkg::addr_commit_t commit,
  output logic                  invalidate
);

  net_pkg::net_state_e state;
  logic                timer_restart;
  logic                second_tick;
  logic                holdoff_tick;
  logic                sec_tick;
  logic [4:0]          sec_count;
  logic [4:0]          sec_next;
  logic                retry_due;
  logic                offer_take;
  logic                renew_active;
  logic [31:0]         renew_secs;

  second_timer #(
    .TICKS_PER_SECOND(TICKS_PER_SECOND)
  ) i_second_timer (
    .tx_clock     (tx_clock),
    .arst_n       (arst_n),
    .restart      (timer_restart),
    .second_tick  (second_tick),
    .holdoff_tick (holdoff_tick)
  );

  // a tick seen while the restart is still pending is from the old phase
  assign sec_tick   = second_tick && !timer_restart;
  assign sec_next   = sec_count + 5'd1;
  assign retry_due  = (sec_next == net_pkg::DHCP_RETRY_1) ||
                      (sec_next == net_pkg::DHCP_RETRY_2) ||
                      (sec_next == net_pkg::DHCP_RETRY_3);
  // listen is only high in wait and hold
  assign offer_take = dhcp_listen && offer_valid;
  assign net_state  = state;

  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n) begin
      state         <= net_pkg::st_wait_link;
      timer_restart <= 1'b0;
      sec_count     <= '0;
      dhcp_request  <= 1'b0;
      dhcp_listen   <= 1'b0;
      dhcp_timeout  <= 1'b0;
      commit_valid  <= 1'b0;
      commit        <= '0;
      invalidate    <= 1'b0;
      renew_active  <= 1'b0;
      renew_secs    <= '0;
    end else begin
      // strobes default low
      dhcp_request  <= 1'b0;
      commit_valid  <= 1'b0;
      invalidate    <= 1'b0;
      timer_restart <= 1'b0;

      if ((state != net_pkg::st_wait_link) && !link_up) begin
        // --------------------
        // link lost
        // --------------------
        // nothing was committed yet while settling
        invalidate   <= (state != net_pkg::st_settle);
        dhcp_listen  <= 1'b0;
        dhcp_timeout <= 1'b0;
        renew_active <= 1'b0;
        state        <= net_pkg::st_wait_link;
      end else if (offer_take) begin
        // offer accepted, renew at half lease or default
        commit_valid  <= 1'b1;
        commit        <= '{source: net_pkg::src_dhcp, dhcp_ip: offer.addr};
        dhcp_listen   <= 1'b0;
        renew_active  <= 1'b1;
        renew_secs    <= (offer.lease == '0) ? net_pkg::DEFAULT_RENEW_SECONDS
                                             : {1'b0, offer.lease[31:1]};
        timer_restart <= 1'b1;
        state         <= net_pkg::st_running;
      end else begin
        case (state)
          net_pkg::st_wait_link: begin
            if (link_up) begin
              sec_count     <= '0;
              timer_restart <= 1'b1;
              state         <= net_pkg::st_settle;
            end
          end

          net_pkg::st_settle: begin
            if (sec_tick && (sec_next == net_pkg::SETTLE_SECONDS)) begin
              if (static_valid) begin
                commit_valid <= 1'b1;
                commit       <= '{source: net_pkg::src_static, dhcp_ip: '0};
                renew_active <= 1'b0;
                state        <= net_pkg::st_running;
              end else begin
                // first discover, seconds count from here
                sec_count <= '0;
                state     <= net_pkg::st_dhcp_request;
              end
            end else if (sec_tick) begin
              sec_count <= sec_next;
            end
          end

          // one cycle here, request strobe is registered
          net_pkg::st_dhcp_request: begin
            dhcp_request  <= 1'b1;
            dhcp_listen   <= 1'b1;
            timer_restart <= 1'b1;
            state         <= net_pkg::st_dhcp_wait;
          end

          net_pkg::st_dhcp_wait: begin
            if (sec_tick) begin
              sec_count <= sec_next;
              if (sec_next == net_pkg::DHCP_GIVE_UP_SECONDS) begin
                // no offer, fall back to 169.254.x.y
                commit_valid <= 1'b1;
                commit       <= '{source: net_pkg::src_link_local, dhcp_ip: '0};
                dhcp_timeout <= 1'b1;
                dhcp_listen  <= 1'b0;
                renew_active <= 1'b0;
                state        <= net_pkg::st_running;
              end else if (retry_due) begin
                timer_restart <= 1'b1;
                state         <= net_pkg::st_dhcp_hold;
              end
            end
          end

          // short gap before the retry goes out
          net_pkg::st_dhcp_hold: begin
            if (holdoff_tick) state <= net_pkg::st_dhcp_request;
          end

          net_pkg::st_running: begin
            // static and link-local never renew
            if (renew_active && sec_tick) begin
              if (renew_secs <= 32'd1) begin
                sec_count    <= '0;
                renew_active <= 1'b0;
                state        <= net_pkg::st_dhcp_request;
              end else begin
                renew_secs <= renew_secs - 32'd1;
              end
            end
          end

          default: state <= net_pkg::st_wait_link;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/addr_result.sv */
/*
  Holds the committed local address, its source and validity.
  Picks static, DHCP or link-local address on each commit from the FSM.
*/
`timescale 1ns/1ps
`default_nettype none

module addr_result (
  input  wire                   tx_clock,
  input  wire                   arst_n,
  input  net_pkg::mac_addr_t    local_mac,
  input  net_pkg::ip_addr_t     static_ip,
  input  wire                   commit_valid,
  input  net_pkg::addr_commit_t commit,
  input  wire                   invalidate,
  output net_pkg::ip_addr_t     local_ip,
  output net_pkg::addr_source_e addr_source,
  output logic                  addr_valid
);

  net_pkg::ip_addr_t commit_ip;

  // address chosen by the commit source
  always_comb begin
    case (commit.source)
      net_pkg::src_static:     commit_ip = static_ip;
      net_pkg::src_dhcp:       commit_ip = commit.dhcp_ip;
      // link-local host part from the MAC low bytes
      net_pkg::src_link_local: commit_ip = {net_pkg::LINK_LOCAL_PREFIX, local_mac[15:0]};
      default:                 commit_ip = '0;
    endcase
  end

  // --------------------
  // result registers
  // --------------------
  always_ff @(posedge tx_clock or negedge arst_n) begin
    if (!arst_n) begin
      local_ip    <= '0;
      addr_source <= net_pkg::src_none;
      addr_valid  <= 1'b0;
    end else if (invalidate) begin
      // keep last address and source visible
      addr_valid <= 1'b0;
    end else if (commit_valid) begin
      local_ip    <= commit_ip;
      addr_source <= commit.source;
      addr_valid  <= (commit.source != net_pkg::src_none);
    end
  end

endmodule

`default_nettype wire

/* verilog/net_addr_ctrl.sv */
/*
  Top level of the address controller: input decode, acquisition FSM
  and result stage, all on tx_clock.
*/
`timescale 1ns/1ps
`default_nettype none

module net_addr_ctrl #(
  parameter logic [31:0] TICKS_PER_SECOND = net_pkg::DEFAULT_TICKS_PER_SECOND
) (
  input  wire                   tx_clock,
  input  wire                   arst_n,
  input  net_pkg::phy_status_t  phy_status,
  input  net_pkg::ip_addr_t     static_ip,
  input  net_pkg::mac_addr_t    local_mac,
  input  wire                   offer_valid,
  input  net_pkg::dhcp_offer_t  offer,
  output logic                  dhcp_request,
  output logic                  dhcp_listen,
  output net_pkg::ip_addr_t     local_ip,
  output net_pkg::addr_source_e addr_source,
  output logic                  addr_valid,
  output logic                  link_up,
  output logic                  speed_1gb,
  output logic                  dhcp_timeout,
  output net_pkg::net_state_e   net_state
);

  logic                  static_valid;
  logic                  commit_valid;
  net_pkg::addr_commit_t commit;
  logic                  invalidate;

  // --------------------
  // decode
  // --------------------
  net_input_decode i_decode (
    .tx_clock     (tx_clock),
    .arst_n       (arst_n),
    .phy_status   (phy_status),
    .static_ip    (static_ip),
    .link_up      (link_up),
    .speed_1gb    (speed_1gb),
    .static_valid (static_valid)
  );

  // --------------------
  // acquisition
  // --------------------
  addr_acquire_fsm #(
    .TICKS_PER_SECOND(TICKS_PER_SECOND)
  ) i_fsm (
    .tx_clock     (tx_clock),
    .arst_n       (arst_n),
    .link_up      (link_up),
    .static_valid (static_valid),
    .offer_valid  (offer_valid),
    .offer        (offer),
    .dhcp_request (dhcp_request),
    .dhcp_listen  (dhcp_listen),
    .dhcp_timeout (dhcp_timeout),
    .net_state    (net_state),
    .commit_valid (commit_valid),
    .commit       (commit),
    .invalidate   (invalidate)
  );

  // --------------------
  // result
  // --------------------
  addr_result i_result (
    .tx_clock     (tx_clock),
    .arst_n       (arst_n),
    .local_mac    (local_mac),
    .static_ip    (static_ip),
    .commit_valid (commit_valid),
    .commit       (commit),
    .invalidate   (invalidate),
    .local_ip     (local_ip),
    .addr_source  (addr_source),
    .addr_valid   (addr_valid)
  );

endmodule

`default_nettype wire

/* bench/tb_addr_model.svh */
/*
  Reference model for the address controller testbench, included inside
  the testbench module. Predicts committed addresses and request timing.
*/
`ifndef TB_ADDR_MODEL_SVH
`define TB_ADDR_MODEL_SVH

// zero and broadcast mean no static address
function automatic bit static_usable(input logic [31:0] ip);
  return (ip != 32'h0000_0000) && (ip != 32'hffff_ffff);
endfunction

// address expected for a given source
function automatic logic [31:0] predict_ip(input net_pkg::addr_source_e src,
                                           input logic [31:0] static_addr,
                                           input logic [47:0] mac,
                                           input logic [31:0] offered);
  case (src)
    net_pkg::src_static:     return static_addr;
    net_pkg::src_dhcp:       return offered;
    // 169.254 plus the MAC's low two bytes
    net_pkg::src_link_local: return {8'd169, 8'd254, mac[15:0]};
    default:                 return 32'h0;
  endcase
endfunction

// seconds after the first request at which request n goes out
function automatic int retry_second(input int n);
  case (n)
    0:       return 0;
    1:       return 1;
    2:       return 3;
    3:       return 7;
    default: return -1;
  endcase
endfunction

// first request plus three retries before the 15 s give-up
function automatic int requests_before_fallback();
  return 4;
endfunction

// renew after half the lease, twelve hours when no lease given
function automatic int renew_seconds(input logic [31:0] lease);
  if (lease == 32'h0) return 43_200;
  return int'(lease / 2);
endfunction

// request may lag its nominal second by the holdoff and restart gaps
function automatic bit offset_in_window(input int n, input int offset,
                                        input int ticks, input int tol);
  int nominal;
  nominal = retry_second(n) * ticks;
  return (offset >= nominal) && (offset <= nominal + tol);
endfunction

`endif

/* bench/tb_net_addr_ctrl.sv */
/*
  Testbench for the address controller: random static, DHCP, fallback
  and link-drop scenarios checked against the included reference model.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_net_addr_ctrl;

  localparam int TPS            = 64;
  localparam int NUM_SCENARIOS  = 8;
  // slack for holdoff and restart cycles over three retries
  localparam int TOL            = 40;
  localparam int TIMEOUT_CYCLES = NUM_SCENARIOS * 20 * TPS + 4 * TPS;

  logic                  tx_clock;
  logic                  arst_n;
  net_pkg::phy_status_t  phy_status;
  net_pkg::ip_addr_t     static_ip;
  net_pkg::mac_addr_t    local_mac;
  logic                  offer_valid;
  net_pkg::dhcp_offer_t  offer;
  logic                  dhcp_request;
  logic                  dhcp_listen;
  net_pkg::ip_addr_t     local_ip;
  net_pkg::addr_source_e addr_source;
  logic                  addr_valid;
  logic                  link_up;
  logic                  speed_1gb;
  logic                  dhcp_timeout;
  net_pkg::net_state_e   net_state;

  int value_errors = 0;
  int other_errors = 0;
  int cycle_count  = 0;
  // cycle stamp of every request pulse in the current scenario
  int req_stamps[$];

  `include "tb_addr_model.svh"

  net_addr_ctrl #(
    .TICKS_PER_SECOND(TPS)
  ) i_dut (
    .tx_clock     (tx_clock),
    .arst_n       (arst_n),
    .phy_status   (phy_status),
    .static_ip    (static_ip),
    .local_mac    (local_mac),
    .offer_valid  (offer_valid),
    .offer        (offer),
    .dhcp_request (dhcp_request),
    .dhcp_listen  (dhcp_listen),
    .local_ip     (local_ip),
    .addr_source  (addr_source),
    .addr_valid   (addr_valid),
    .link_up      (link_up),
    .speed_1gb    (speed_1gb),
    .dhcp_timeout (dhcp_timeout),
    .net_state    (net_state)
  );

  initial begin
    tx_clock = 1'b0;
    forever #50 tx_clock = ~tx_clock;
  end

  // --------------------
  // monitor and timeout
  // --------------------
  always @(posedge tx_clock) begin
    cycle_count = cycle_count + 1;
    if (dhcp_request === 1'b1) req_stamps.push_back(cycle_count);
  end

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    other_errors++;
    $display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
    $display("TEST FAILED");
    $finish;
  end

  // drive and sample point just after the rising edge
  task automatic step();
    @(posedge tx_clock);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("error at t=%0t: %s", $time, what);
    other_errors++;
  endtask

  task automatic wait_addr_valid(input logic level, input int max_cycles, input string what);
    int n;
    n = 0;
    while ((addr_valid !== level) && (n < max_cycles)) begin
      step();
      n++;
    end
    if (addr_valid !== level) report_failure({what, " did not happen in time"});
  endtask

  task automatic wait_link_up(input logic level, input int max_cycles, input string what);
    int n;
    n = 0;
    while ((link_up !== level) && (n < max_cycles)) begin
      step();
      n++;
    end
    if (link_up !== level) report_failure({what, " did not happen in time"});
  endtask

  task automatic wait_request_count(input int target, input int max_cycles, input string what);
    int n;
    n = 0;
    while ((req_stamps.size() < target) && (n < max_cycles)) begin
      step();
      n++;
    end
    if (req_stamps.size() < target) report_failure({what, " never arrived"});
  endtask

  // --------------------
  // link control
  // --------------------
  task automatic bring_link_up();
    logic [1:0] spd;
    spd = ($urandom % 2) ? 2'b10 : 2'b01;
    req_stamps.delete();
    phy_status = '{speed: spd, duplex: 1'b1};
    wait_link_up(1'b1, 8, "link up");
    check_value("speed_1gb", spd[1], speed_1gb);
  endtask

  // clear duplex and hold the link down for a random time
  task automatic drop_link();
    int n_req;
    int hold;
    phy_status.duplex = 1'b0;
    wait_link_up(1'b0, 8, "link down");
    wait_addr_valid(1'b0, 8, "addr_valid drop on link loss");
    n_req = req_stamps.size();
    hold  = 32 + ($urandom % 64);
    repeat (hold) step();
    check_value("dhcp_request count while down", n_req, req_stamps.size());
    check_value("addr_valid", 1'b0, addr_valid);
    check_value("dhcp_listen", 1'b0, dhcp_listen);
    check_value("dhcp_timeout", 1'b0, dhcp_timeout);
    check_value("net_state", net_pkg::st_wait_link, net_state);
  endtask

  task automatic check_idle();
    check_value("dhcp_request", 1'b0, dhcp_request);
    check_value("dhcp_listen", 1'b0, dhcp_listen);
    check_value("addr_valid", 1'b0, addr_valid);
    check_value("link_up", 1'b0, link_up);
    check_value("dhcp_timeout", 1'b0, dhcp_timeout);
    check_value("net_state", net_pkg::st_wait_link, net_state);
  endtask

  // --------------------
  // scenarios
  // --------------------
  task automatic run_static();
    logic [31:0] held_ip;
    static_ip = $urandom;
    while (!static_usable(static_ip)) static_ip = $urandom;
    bring_link_up();
    wait_addr_valid(1'b1, 2 * TPS + 16, "static address commit");
    held_ip = predict_ip(net_pkg::src_static, static_ip, local_mac, 32'h0);
    check_value("local_ip", held_ip, local_ip);
    check_value("addr_source", net_pkg::src_static, addr_source);
    check_value("dhcp_listen", 1'b0, dhcp_listen);
    // stray offer while not listening
    offer_valid = 1'b1;
    offer       = '{addr: $urandom, lease: 32'd2};
    step();
    offer_valid = 1'b0;
    repeat (2 * TPS) step();
    check_value("local_ip", held_ip, local_ip);
    check_value("addr_source", net_pkg::src_static, addr_source);
    check_value("addr_valid", 1'b1, addr_valid);
    check_value("dhcp_request count", 0, req_stamps.size());
  endtask

  task automatic run_fallback();
    int offset;
    static_ip = ($urandom % 2) ? 32'h0 : 32'hffff_ffff;
    bring_link_up();
    wait_addr_valid(1'b1, 17 * TPS, "link-local fallback");
    check_value("dhcp_request count", requests_before_fallback(), req_stamps.size());
    for (int n = 1; n < req_stamps.size() && n < 4; n++) begin
      offset = req_stamps[n] - req_stamps[0];
      if (!offset_in_window(n, offset, TPS, TOL)) begin
        $display("ERR t=%0t dhcp_request %0d offset expected=%0d..%0d actual=%0d",
                 $time, n, retry_second(n) * TPS, retry_second(n) * TPS + TOL, offset);
        value_errors++;
      end
    end
    check_value("local_ip", predict_ip(net_pkg::src_link_local, static_ip, local_mac, 32'h0),
                local_ip);
    check_value("addr_source", net_pkg::src_link_local, addr_source);
    check_value("dhcp_timeout", 1'b1, dhcp_timeout);
    check_value("dhcp_listen", 1'b0, dhcp_listen);
    // no further requests once fallen back
    repeat (TPS) step();
    check_value("dhcp_request count", requests_before_fallback(), req_stamps.size());
  endtask

  task automatic run_offer(input bit zero_lease);
    int          delay;
    int          n_req;
    int          offer_cycle;
    int          offset;
    logic [31:0] offered;
    logic [31:0] lease;
    static_ip = ($urandom % 2) ? 32'h0 : 32'hffff_ffff;
    bring_link_up();
    wait_request_count(1, 2 * TPS + 16, "first DHCP request");
    delay = $urandom % (5 * TPS);
    repeat (delay) step();
    check_value("dhcp_listen", 1'b1, dhcp_listen);
    offered     = $urandom;
    lease       = zero_lease ? 32'd0 : 32'd1 + ($urandom % 3);
    offer_valid = 1'b1;
    offer       = '{addr: offered, lease: lease};
    step();
    offer_valid = 1'b0;
    // renewal time counts from the edge that took the offer
    offer_cycle = cycle_count;
    n_req       = req_stamps.size();
    wait_addr_valid(1'b1, 8, "DHCP address commit");
    check_value("local_ip", predict_ip(net_pkg::src_dhcp, static_ip, local_mac, offered),
                local_ip);
    check_value("addr_source", net_pkg::src_dhcp, addr_source);
    check_value("dhcp_listen", 1'b0, dhcp_listen);
    check_value("dhcp_timeout", 1'b0, dhcp_timeout);
    if (zero_lease) begin
      repeat (4 * TPS) step();
      check_value("dhcp_request count", n_req, req_stamps.size());
    end else begin
      wait_request_count(n_req + 1, (renew_seconds(lease) + 1) * TPS + 16, "renewal request");
      // renewal may not go out before half the lease
      if (req_stamps.size() > n_req) begin
        offset = req_stamps[n_req] - offer_cycle;
        if (offset < renew_seconds(lease) * TPS) begin
          $display("ERR t=%0t dhcp_request renewal offset expected>=%0d actual=%0d",
                   $time, renew_seconds(lease) * TPS, offset);
          value_errors++;
        end
      end
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    int          seed;
    int          mode;
    logic [31:0] mac_hi;
    logic [31:0] mac_lo;
    seed        = $urandom(49650);
    arst_n      = 1'b0;
    phy_status  = '0;
    static_ip   = '0;
    local_mac   = '0;
    offer_valid = 1'b0;
    offer       = '0;
    repeat (16) @(posedge tx_clock);
    #1;
    arst_n = 1'b1;
    // quiet until the link comes up
    repeat (20) begin
      step();
      check_idle();
      check_value("local_ip", 32'h0, local_ip);
      check_value("addr_source", net_pkg::src_none, addr_source);
    end
    for (int i = 0; i < NUM_SCENARIOS; i++) begin
      // first four cover every mode and the rest are random
      mode      = (i < 4) ? i : ($urandom % 4);
      mac_hi    = $urandom;
      mac_lo    = $urandom;
      local_mac = {mac_hi[15:0], mac_lo};
      case (mode)
        0:       run_static();
        1:       run_fallback();
        2:       run_offer(1'b1);
        default: run_offer(1'b0);
      endcase
      drop_link();
    end
    $display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+bench
verilog/net_pkg.sv
verilog/net_input_decode.sv
verilog/second_timer.sv
verilog/addr_acquire_fsm.sv
verilog/addr_result.sv
verilog/net_addr_ctrl.sv
bench/tb_net_addr_ctrl.sv
